//--- common/fetch_pkg.sv
/*
 * shared constants and bus/record structs for the fetch front end
 */
package fetch_pkg;

    localparam int LINE_BYTES = 16;              // bytes per fetched line
    localparam int LINE_W     = LINE_BYTES * 8;
    localparam int ADDR_W     = 32;              // byte address width

    localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_1000; // line aligned

    // line fifo sizing, depth kept a power of two
    localparam int FIFO_DEPTH = 2;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // wishbone classic request, master side
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;   // reads only
        logic [ADDR_W-1:0] adr;  // line address in bytes
    } wb_req_t;

    // wishbone classic response, slave side
    typedef struct packed {
        logic              ack;
        logic [LINE_W-1:0] dat;
    } wb_rsp_t;

    // one issued instruction
    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        logic [31:0]       instr;      // upper half zero when compressed
        logic              compressed;
    } instr_t;

endpackage

//--- fetch/fetch_wb_master.sv
/*
 * wishbone classic read master, fetches sequential lines
 * from RESET_PC and pushes them into the line fifo
 */
`timescale 1ns/1ps

module fetch_wb_master (
    input  logic                         clk_i,
    input  logic                         rstn_i,

    // memory bus
    output fetch_pkg::wb_req_t           wb_req_o,
    input  fetch_pkg::wb_rsp_t           wb_rsp_i,

    // line fifo side
    input  logic                         room_i,
    output logic                         push_o,
    output logic [fetch_pkg::LINE_W-1:0] push_line_o
);

    import fetch_pkg::*;

    logic              busy_q;     // one transfer in flight
    logic [ADDR_W-1:0] adr_q;      // address of the current or next line
    logic              start;
    logic              done;

    // a new transfer only from idle, never in the ack cycle
    assign start = !busy_q && room_i;
    assign done  = busy_q && wb_rsp_i.ack;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q <= 1'b0;
            adr_q  <= RESET_PC;
        end else begin
            if (done) begin
                busy_q <= 1'b0;
                adr_q  <= adr_q + ADDR_W'(LINE_BYTES); // next sequential line
            end else if (start) begin
                busy_q <= 1'b1;
            end
        end
    end

    always_comb begin
        wb_req_o.cyc = busy_q;
        wb_req_o.stb = busy_q;
        wb_req_o.we  = 1'b0;
        wb_req_o.adr = adr_q;
    end

    // line goes straight into the fifo on ack
    assign push_o      = done;
    assign push_line_o = wb_rsp_i.dat;

    // classic handshake: request held until the slave acks
    a_req_hold: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (wb_req_o.stb && !wb_rsp_i.ack) |=> (wb_req_o.stb && $stable(wb_req_o.adr))
    ) else $error("wishbone request dropped or address changed before ack");

endmodule

//--- fetch/fetch_line_fifo.sv
/*
 * show-ahead register fifo holding fetched instruction lines
 */
`timescale 1ns/1ps

module fetch_line_fifo (
    input  logic                         clk_i,
    input  logic                         rstn_i,

    input  logic                         push_i,
    input  logic [fetch_pkg::LINE_W-1:0] push_line_i,

    input  logic                         pop_i,
    output logic [fetch_pkg::LINE_W-1:0] head_o,
    output logic                         empty_o,
    output logic                         room_o
);

    import fetch_pkg::*;

    logic [LINE_W-1:0]     mem_q [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [FIFO_CNT_W-1:0] count_q;

    // storage, no reset needed
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_line_i;
        end
    end

    // pointers wrap naturally since depth is a power of two
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;   // both or neither
            endcase
        end
    end

    assign head_o  = mem_q[rd_ptr_q];   // show-ahead
    assign empty_o = (count_q == '0);

    // a pending push already claims the free slot
    assign room_o = (count_q < FIFO_CNT_W'(FIFO_DEPTH)) && !push_i;

    a_no_pop_empty: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        pop_i |-> !empty_o
    ) else $error("line fifo popped while empty");

endmodule

//--- fetch/fetch_adapter.sv
/*
 * two-line buffer between the line fifo and the issue stage,
 * exposes a 32-bit byte window and consumes 2 or 4 bytes per read
 */
`timescale 1ns/1ps

module fetch_adapter (
    input  logic                         clk_i,
    input  logic                         rstn_i,

    // line fifo side
    input  logic                         fifo_empty_i,
    input  logic [fetch_pkg::LINE_W-1:0] fifo_head_i,
    output logic                         fifo_pop_o,

    // byte window towards the issue stage
    output logic [31:0]                  window_o,
    output logic [2:0]                   avail_o,   // buffered bytes, capped at 4
    input  logic                         consume_i,
    input  logic                         size_i     // 0: 2 bytes, 1: 4 bytes
);

    import fetch_pkg::*;

    logic [LINE_W-1:0]   lines_q [2];
    logic [1:0]          fill_q;        // extra bit tells full from empty
    logic [1:0]          active_q;
    logic [4:0]          bytes_left_q;  // left in the active line
    logic [1:0]          line_cnt;
    logic                full;
    logic                fill_slot;
    logic                active_slot;
    logic [3:0]          offset;        // byte offset in the active line
    logic [2*LINE_W-1:0] pair;
    logic [5:0]          buffered;
    logic [4:0]          step;
    logic                line_done;

    assign fill_slot   = fill_q[0];
    assign active_slot = active_q[0];
    assign line_cnt    = fill_q - active_q;
    assign full        = (line_cnt == 2'd2);

    // take the head line as soon as a slot is free
    assign fifo_pop_o = !fifo_empty_i && !full;

    always_ff @(posedge clk_i) begin
        if (fifo_pop_o) begin
            lines_q[fill_slot] <= fifo_head_i;
        end
    end

    // window spans active and next line, so straddling words come out whole
    assign offset   = 4'(5'(LINE_BYTES) - bytes_left_q);
    assign pair     = {lines_q[~active_slot], lines_q[active_slot]};
    assign window_o = pair[{offset, 3'b000} +: 32];

    always_comb begin
        if (line_cnt == 2'd0) begin
            buffered = '0;
        end else if (line_cnt == 2'd1) begin
            buffered = {1'b0, bytes_left_q};
        end else begin
            buffered = {1'b0, bytes_left_q} + 6'(LINE_BYTES);
        end
    end

    assign avail_o = (buffered > 6'd4) ? 3'd4 : buffered[2:0];

    // read side
    assign step      = size_i ? 5'd4 : 5'd2;
    assign line_done = consume_i && (step >= bytes_left_q);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            fill_q       <= '0;
            active_q     <= '0;
            bytes_left_q <= 5'(LINE_BYTES);
        end else begin
            if (fifo_pop_o) begin
                fill_q <= fill_q + 2'd1;
            end
            if (line_done) begin
                // frees the slot, remainder of a straddling read comes off the next line
                active_q     <= active_q + 2'd1;
                bytes_left_q <= bytes_left_q + 5'(LINE_BYTES) - step;
            end else if (consume_i) begin
                bytes_left_q <= bytes_left_q - step;
            end
        end
    end

    a_consume_avail: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        consume_i |-> (size_i ? (avail_o == 3'd4) : (avail_o >= 3'd2))
    ) else $error("issue stage consumed more bytes than buffered");

endmodule

//--- fetch/fetch_issue.sv
/*
 * issue stage: length detection, program counter
 * and a registered valid/ready instruction output
 */
`timescale 1ns/1ps

module fetch_issue (
    input  logic                clk_i,
    input  logic                rstn_i,

    // adapter side
    input  logic [31:0]         window_i,
    input  logic [2:0]          avail_i,
    output logic                consume_o,
    output logic                size_o,

    // instruction stream
    output fetch_pkg::instr_t   instr_o,
    output logic                instr_valid_o,
    input  logic                instr_ready_i
);

    import fetch_pkg::*;

    logic              is_full;    // 32-bit encoding
    logic [2:0]        need;
    logic              slot_free;
    logic [ADDR_W-1:0] pc_q;
    logic              valid_q;
    instr_t            instr_q;

    assign is_full = (window_i[1:0] == 2'b11);
    assign need    = is_full ? 3'd4 : 3'd2;
    assign size_o  = is_full;

    // output slot empty or being taken this cycle
    assign slot_free = !valid_q || instr_ready_i;
    assign consume_o = slot_free && (avail_i >= need);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q    <= RESET_PC;
            valid_q <= 1'b0;
        end else begin
            if (consume_o) begin
                pc_q    <= pc_q + ADDR_W'(need);
                valid_q <= 1'b1;
            end else if (instr_ready_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    // record payload
    always_ff @(posedge clk_i) begin
        if (consume_o) begin
            instr_q.pc         <= pc_q;
            instr_q.instr      <= is_full ? window_i : {16'h0000, window_i[15:0]};
            instr_q.compressed <= !is_full;
        end
    end

    assign instr_o       = instr_q;
    assign instr_valid_o = valid_q;

    a_hold_stalled: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (instr_valid_o && !instr_ready_i) |=> (instr_valid_o && $stable(instr_o))
    ) else $error("instruction record changed while stalled");

endmodule

//--- verilog/fetch_top.sv
/*
 * fetch front end top: wishbone master, line fifo, adapter, issue stage
 */
`timescale 1ns/1ps

module fetch_top (
    input  logic               clk_i,
    input  logic               rstn_i,

    output fetch_pkg::wb_req_t wb_req_o,
    input  fetch_pkg::wb_rsp_t wb_rsp_i,

    output fetch_pkg::instr_t  instr_o,
    output logic               instr_valid_o,
    input  logic               instr_ready_i
);

    import fetch_pkg::*;

    logic              room;
    logic              push;
    logic [LINE_W-1:0] push_line;
    logic              pop;
    logic [LINE_W-1:0] head;
    logic              empty;
    logic [31:0]       window;
    logic [2:0]        avail;
    logic              consume;
    logic              size;

    fetch_wb_master master_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .wb_req_o    (wb_req_o),
        .wb_rsp_i    (wb_rsp_i),
        .room_i      (room),
        .push_o      (push),
        .push_line_o (push_line)
    );

    fetch_line_fifo fifo_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .push_i      (push),
        .push_line_i (push_line),
        .pop_i       (pop),
        .head_o      (head),
        .empty_o     (empty),
        .room_o      (room)
    );

    fetch_adapter adapter_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .fifo_empty_i (empty),
        .fifo_head_i  (head),
        .fifo_pop_o   (pop),
        .window_o     (window),
        .avail_o      (avail),
        .consume_i    (consume),
        .size_i       (size)
    );

    fetch_issue issue_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .window_i      (window),
        .avail_i       (avail),
        .consume_o     (consume),
        .size_o        (size),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid_o),
        .instr_ready_i (instr_ready_i)
    );

endmodule

//--- testbench/tb_mem_slave.sv
/*
 * wishbone classic memory model for the fetch testbench,
 * random acknowledge delay and bus protocol checks
 */
`timescale 1ns/1ps

module tb_mem_slave #(
    parameter int MEM_LINES = 256
) (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  fetch_pkg::wb_req_t wb_req_i,
    output fetch_pkg::wb_rsp_t wb_rsp_o,
    input  logic [1:0]         delay_i,    // extra wait cycles for a new request
    output logic               err_o
);

    import fetch_pkg::*;

    localparam int IDX_W = $clog2(MEM_LINES);
    localparam int OFF_W = $clog2(LINE_BYTES);

    logic [LINE_W-1:0] mem_q [MEM_LINES];  // filled by the testbench at time zero
    logic [ADDR_W-1:0] exp_adr_q;          // next sequential line
    logic [ADDR_W-1:0] held_adr_q;
    logic              waiting_q;          // request seen, ack not yet given
    logic [1:0]        wait_q;
    logic [ADDR_W-1:0] off;

    assign off = wb_req_i.adr - RESET_PC;

    always @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wb_rsp_o   <= '0;
            exp_adr_q  <= RESET_PC;
            held_adr_q <= '0;
            waiting_q  <= 1'b0;
            wait_q     <= '0;
            err_o      <= 1'b0;
        end else begin
            wb_rsp_o.ack <= 1'b0;   // ack lasts one cycle
            if (wb_req_i.we) begin
                $display("bus error at %0t ns: write enable raised on a read-only bus",
                         $time);
                err_o <= 1'b1;
            end
            if (wb_req_i.cyc && wb_req_i.stb && !wb_rsp_o.ack) begin
                if (waiting_q && wb_req_i.adr != held_adr_q) begin
                    $display("bus error at %0t ns: address changed from %h to %h before ack",
                             $time, held_adr_q, wb_req_i.adr);
                    err_o <= 1'b1;
                end
                if (!waiting_q && wb_req_i.adr != exp_adr_q) begin
                    $display("bus error at %0t ns: request for line %h, next line is %h",
                             $time, wb_req_i.adr, exp_adr_q);
                    err_o <= 1'b1;
                end
                if (off >= ADDR_W'(MEM_LINES * LINE_BYTES)) begin
                    $display("bus error at %0t ns: address %h is outside the memory model",
                             $time, wb_req_i.adr);
                    err_o <= 1'b1;
                end
                // delay counts from the first cycle the request is seen
                if (waiting_q ? (wait_q == 2'd0) : (delay_i == 2'd0)) begin
                    wb_rsp_o.ack <= 1'b1;
                    wb_rsp_o.dat <= mem_q[off[IDX_W+OFF_W-1:OFF_W]];
                    exp_adr_q    <= exp_adr_q + ADDR_W'(LINE_BYTES);
                    waiting_q    <= 1'b0;
                end else if (waiting_q) begin
                    wait_q <= wait_q - 2'd1;
                end else begin
                    waiting_q  <= 1'b1;
                    held_adr_q <= wb_req_i.adr;
                    wait_q     <= delay_i - 2'd1;
                end
            end
        end
    end

endmodule

//--- testbench/tb_fetch.sv
/*
 * testbench for the fetch front end: clock, reset, random back-pressure,
 * reference instruction model, field checks and timeout
 */
`timescale 1ns/1ps

module tb_fetch;

    import fetch_pkg::*;

    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 16;
    localparam int RESET_CYCLES   = 4;
    localparam int STALL_AT       = 150;   // accepted count that starts the long stall
    localparam int STALL_CYCLES   = 40;
    localparam int MEM_LINES      = 256;
    localparam int IDX_W          = $clog2(MEM_LINES);
    localparam int OFF_W          = $clog2(LINE_BYTES);

    logic        clk;
    logic        rstn;
    logic        instr_ready;
    logic [1:0]  ack_delay;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    instr_t      instr;
    logic        instr_valid;
    logic        bus_err;

    logic [31:0]       lfsr_q;
    int                cycle_cnt;
    int                rst_cycles;
    int                accepted;
    int                straddles;
    int                stall_left;
    logic              stall_done;
    logic              post_reset_seen;
    logic              hold_pending;
    instr_t            held_instr;
    logic [ADDR_W-1:0] exp_pc;

    fetch_top dut_i (
        .clk_i         (clk),
        .rstn_i        (rstn),
        .wb_req_o      (wb_req),
        .wb_rsp_i      (wb_rsp),
        .instr_o       (instr),
        .instr_valid_o (instr_valid),
        .instr_ready_i (instr_ready)
    );

    tb_mem_slave #(
        .MEM_LINES (MEM_LINES)
    ) mem_i (
        .clk_i    (clk),
        .rstn_i   (rstn),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp),
        .delay_i  (ack_delay),
        .err_o    (bus_err)
    );

    always #2 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            bits   = {bits[30:0], lfsr_q[0]};   // one step per bit
        end
    endtask

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Mismatch at %0t ns: %s is 0x%08h, expected 0x%08h",
                     $time, name, got, want);
            abort_run();
        end
    endtask

    function automatic logic [7:0] mem_byte(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] off;
        logic [LINE_W-1:0] line;
        off  = addr - RESET_PC;
        line = mem_i.mem_q[off[IDX_W+OFF_W-1:OFF_W]];
        return line[{addr[3:0], 3'b000} +: 8];
    endfunction

    // length rule applied to the memory image
    function automatic instr_t expect_instr(input logic [ADDR_W-1:0] pc);
        instr_t      r;
        logic [15:0] lo;
        logic [15:0] hi;
        lo   = {mem_byte(pc + 1), mem_byte(pc)};
        hi   = {mem_byte(pc + 3), mem_byte(pc + 2)};
        r.pc = pc;
        if (lo[1:0] == 2'b11) begin
            r.instr      = {hi, lo};
            r.compressed = 1'b0;
        end else begin
            r.instr      = {16'h0000, lo};
            r.compressed = 1'b1;
        end
        return r;
    endfunction

    initial begin
        logic [31:0]       bits;
        logic [LINE_W-1:0] line;
        clk             = 1'b0;
        rstn            = 1'b0;
        instr_ready     = 1'b0;
        ack_delay       = 2'd0;
        lfsr_q          = 32'h2aa7;
        cycle_cnt       = 0;
        rst_cycles      = 0;
        accepted        = 0;
        straddles       = 0;
        stall_left      = 0;
        stall_done      = 1'b0;
        post_reset_seen = 1'b0;
        hold_pending    = 1'b0;
        exp_pc          = RESET_PC;
        for (int l = 0; l < MEM_LINES; l++) begin
            line = '0;
            for (int p = 0; p < LINE_BYTES / 2; p++) begin
                draw_bits(16, bits);
                line = {bits[15:0], line[LINE_W-1:16]};  // parcel 0 drawn first
            end
            mem_i.mem_q[IDX_W'(l)] = line;
        end
    end

    // stimulus
    always @(posedge clk) begin
        logic [31:0] bits;
        cycle_cnt = cycle_cnt + 1;
        if (rst_cycles < RESET_CYCLES) begin
            rst_cycles = rst_cycles + 1;
            if (rst_cycles == RESET_CYCLES) begin
                rstn <= 1'b1;
            end
        end
        draw_bits(2, bits);
        ack_delay <= bits[1:0];
        if (!stall_done && accepted >= STALL_AT) begin
            stall_left = STALL_CYCLES;
            stall_done = 1'b1;
        end
        if (stall_left > 0) begin
            instr_ready <= 1'b0;
            stall_left = stall_left - 1;
        end else begin
            draw_bits(2, bits);
            instr_ready <= (bits[1:0] != 2'b00);  // ready about 3 of 4 cycles
        end
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with only %0d of %0d instructions accepted",
                     cycle_cnt, accepted, NUM_INSTR);
            abort_run();
        end
    end

    // outputs have settled since the last rising edge
    always @(negedge clk) begin
        instr_t want;
        if (bus_err) begin
            $display("the memory model saw a Wishbone protocol violation");
            abort_run();
        end
        if (!rstn || !post_reset_seen) begin
            check_value("wb_req_o.cyc", 32'(wb_req.cyc), 32'd0);
            check_value("wb_req_o.stb", 32'(wb_req.stb), 32'd0);
            check_value("instr_valid_o", 32'(instr_valid), 32'd0);
            if (rstn) begin
                post_reset_seen = 1'b1;
            end
        end
        // stalled record must not move
        if (hold_pending) begin
            check_value("instr_valid_o", 32'(instr_valid), 32'd1);
            check_value("instr_o.pc", instr.pc, held_instr.pc);
            check_value("instr_o.instr", instr.instr, held_instr.instr);
            check_value("instr_o.compressed", 32'(instr.compressed),
                        32'(held_instr.compressed));
        end
        hold_pending = instr_valid && !instr_ready;
        held_instr   = instr;
        if (instr_valid && instr_ready) begin
            want = expect_instr(exp_pc);
            check_value("instr_o.pc", instr.pc, want.pc);
            check_value("instr_o.instr", instr.instr, want.instr);
            check_value("instr_o.compressed", 32'(instr.compressed), 32'(want.compressed));
            if (!want.compressed && want.pc[3:0] == 4'd14) begin
                straddles = straddles + 1;
            end
            exp_pc   = exp_pc + (want.compressed ? 32'd2 : 32'd4);
            accepted = accepted + 1;
            if (accepted == NUM_INSTR) begin
                if (straddles > 0) begin
                    $display("%0d instructions checked, %0d crossed a line boundary",
                             accepted, straddles);
                    $display("TESTS PASSED");
                    $finish;
                end else begin
                    $display("no 32-bit instruction crossed a line boundary");
                    abort_run();
                end
            end
        end
    end

endmodule

//--- filelist.f
common/fetch_pkg.sv
fetch/fetch_wb_master.sv
fetch/fetch_line_fifo.sv
fetch/fetch_adapter.sv
fetch/fetch_issue.sv
verilog/fetch_top.sv
testbench/tb_mem_slave.sv
testbench/tb_fetch.sv

//--- run.sh
#!/bin/sh
# builds the fetch front end testbench with Verilator and runs it
# the exit status of the simulation is the result of the run
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_fetch \
    -f filelist.f \
    -o sim_fetch

./obj_dir/sim_fetch
